/* src/i2c_pkg.sv */
package i2c_pkg;

	// transfer result, reported by the engine and held by the controller
	typedef enum logic [1:0] {
		I2C_NO_ERR          = 2'd0,
		I2C_ERR_NO_ADDR_ACK = 2'd1, // slave did not answer its address
		I2C_ERR_NO_DATA_ACK = 2'd2  // slave refused a data byte
	} i2c_status_t;

	// host command word
	typedef struct packed {
		logic [7:0] slave_addr; // [7:1] address, [0] read
		logic [7:0] count;      // data bytes, at least 1
	} i2c_cmd_t;

	// sda level in the ninth bit slot
	localparam logic I2C_ACK = 1'b0;
	localparam logic I2C_NAK = 1'b1;

endpackage

/* src/i2c_scl_gen.sv */
`timescale 1ns/100ps

module i2c_scl_gen #(
	parameter int SCL_DIV = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	output logic scl,
	output logic scl_delay
);

	localparam int CW  = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;
	localparam int DLY = (SCL_DIV > 1) ? SCL_DIV / 2 : 1;

	logic [CW-1:0]  div_cnt;
	logic [DLY-1:0] dly_line;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			scl     <= 1'b1;
		end else if (!run) begin
			div_cnt <= '0;
			scl     <= 1'b1; // parked high between transfers
		end else if (div_cnt == CW'(SCL_DIV - 1)) begin
			div_cnt <= '0;
			scl     <= ~scl;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// half a phase behind scl, marks the middle of the high phase
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dly_line <= '1;
		end else begin
			dly_line <= (dly_line << 1) | DLY'(scl);
		end
	end

	assign scl_delay = dly_line[DLY-1];

endmodule

/* src/i2c_byte_fifo.sv */
`timescale 1ns/100ps

module i2c_byte_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push,
	input  logic [7:0] wr_data,
	input  logic       pop,
	output logic [7:0] rd_data,
	output logic       full,
	output logic       empty
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [7:0]    mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   fill;
	logic          do_push;
	logic          do_pop;

	assign full    = (fill == (AW+1)'(FIFO_DEPTH));
	assign empty   = (fill == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= wr_data;
		if (do_pop) rd_data <= mem[rd_ptr]; // valid the cycle after pop
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

/* src/i2c_bit_engine.sv */
`timescale 1ns/100ps

module i2c_bit_engine (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                scl,
	input  logic                scl_delay,
	input  logic                sda_i,
	output logic                sda_o,
	output logic                sda_oe,
	input  logic [7:0]          slave_addr,
	input  logic [7:0]          tx_byte,
	output logic                byte_pop,
	output logic [7:0]          rx_byte,
	output logic                byte_push,
	input  logic [7:0]          remaining,
	input  logic                start,
	input  logic                stop,
	output logic                ack_done,
	output i2c_pkg::i2c_status_t status,
	output logic                bus_idle
);

	typedef enum logic [3:0] {
		ST_IDLE, ST_START, ST_START_OUT, ST_STOP_WAIT, ST_STOP, ST_STOP_OUT,
		ST_OUT_BIT, ST_CHECK_OUT, ST_IN_BIT, ST_CHECK_IN, ST_DATA_LOOP,
		ST_ACK, ST_WAIT
	} state_t;

	typedef enum logic [1:0] {STREAM_NONE, STREAM_ADDR, STREAM_RD, STREAM_WR} stream_t;

	state_t     state;
	stream_t    stream;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic       start_pend;
	logic       stop_pend;
	logic       sda_line;

	assign bus_idle = (state == ST_IDLE) && !start_pend && !stop_pend && !start && !stop;
	assign sda_line = sda_oe ? sda_o : 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			stream     <= STREAM_NONE;
			bit_cnt    <= '0;
			shift      <= '0;
			rx_byte    <= '0;
			sda_o      <= 1'b1;
			sda_oe     <= 1'b0;
			byte_pop   <= 1'b0;
			byte_push  <= 1'b0;
			ack_done   <= 1'b0;
			status     <= i2c_pkg::I2C_NO_ERR;
			start_pend <= 1'b0;
			stop_pend  <= 1'b0;
		end else begin
			byte_pop  <= 1'b0;
			byte_push <= 1'b0;
			ack_done  <= 1'b0;
			status    <= i2c_pkg::I2C_NO_ERR;
			if (start) start_pend <= 1'b1;
			if (stop) stop_pend <= 1'b1;

			case (state)
				ST_START: if (scl) state <= ST_START_OUT;
				ST_START_OUT: begin
					if (scl_delay) begin
						sda_o   <= 1'b0; // start condition
						bit_cnt <= '0;
						stream  <= STREAM_ADDR;
						state   <= ST_OUT_BIT;
					end
				end
				ST_STOP_WAIT: begin
					if (!scl) begin
						sda_o  <= 1'b0;
						sda_oe <= 1'b1;
						state  <= ST_STOP;
					end
				end
				ST_STOP: if (scl) state <= ST_STOP_OUT;
				ST_STOP_OUT: begin
					if (scl_delay) begin
						sda_o  <= 1'b1; // stop condition, then release
						sda_oe <= 1'b0;
						stream <= STREAM_NONE;
						state  <= ST_IDLE;
					end
				end
				ST_OUT_BIT: begin
					if (!scl) begin
						if (bit_cnt == 3'd0) begin
							sda_o <= (stream == STREAM_ADDR) ? slave_addr[7] : tx_byte[7];
							shift <= (stream == STREAM_ADDR) ? {slave_addr[6:0], 1'b0}
							                                 : {tx_byte[6:0], 1'b0};
						end else begin
							sda_o <= shift[7];
							shift <= {shift[6:0], 1'b0};
						end
						sda_oe <= 1'b1;
						state  <= ST_DATA_LOOP;
					end
				end
				ST_CHECK_OUT: begin
					if (!scl) begin
						sda_oe <= 1'b0; // slave answers
						state  <= ST_ACK;
					end
				end
				ST_IN_BIT: begin
					if (!scl) begin
						sda_oe <= 1'b0;
						state  <= ST_DATA_LOOP;
					end
				end
				ST_CHECK_IN: begin
					if (!scl) begin
						// nak the last byte of a read
						sda_o  <= (remaining == 8'd0) ? i2c_pkg::I2C_NAK : i2c_pkg::I2C_ACK;
						sda_oe <= 1'b1;
						state  <= ST_ACK;
					end
				end
				ST_DATA_LOOP: begin
					if (scl) begin
						if (stream == STREAM_RD) begin
							rx_byte <= {rx_byte[6:0], sda_i};
							if (bit_cnt == 3'd7) byte_push <= 1'b1;
							state <= (bit_cnt == 3'd7) ? ST_CHECK_IN : ST_IN_BIT;
						end else begin
							state <= (bit_cnt == 3'd7) ? ST_CHECK_OUT : ST_OUT_BIT;
						end
						bit_cnt <= bit_cnt + 3'd1;
					end
				end
				ST_ACK: begin
					if (scl) begin
						ack_done <= 1'b1;
						case (stream)
							STREAM_ADDR: begin
								if (sda_i == i2c_pkg::I2C_ACK) begin
									byte_pop <= !slave_addr[0]; // prefetch first write byte
									stream   <= slave_addr[0] ? STREAM_RD : STREAM_WR;
									state    <= slave_addr[0] ? ST_IN_BIT : ST_OUT_BIT;
								end else begin
									status <= i2c_pkg::I2C_ERR_NO_ADDR_ACK;
									stream <= STREAM_NONE;
									state  <= ST_WAIT;
								end
							end
							STREAM_WR: begin
								if (sda_i == i2c_pkg::I2C_ACK) begin
									byte_pop <= 1'b1;
									state    <= ST_OUT_BIT;
								end else begin
									status <= i2c_pkg::I2C_ERR_NO_DATA_ACK;
									stream <= STREAM_NONE;
									state  <= ST_WAIT;
								end
							end
							STREAM_RD: state <= ST_IN_BIT;
							default:   state <= ST_WAIT;
						endcase
					end
				end
				default: begin
				end
			endcase

			// pending requests wait for their scl phase
			if (start_pend && !scl && state == ST_IDLE) begin
				sda_o      <= 1'b1;
				sda_oe     <= 1'b1;
				start_pend <= 1'b0;
				state      <= ST_START;
			end
			if (stop_pend && scl && !(state inside {ST_STOP_WAIT, ST_STOP, ST_STOP_OUT})) begin
				stop_pend <= 1'b0;
				state     <= ST_STOP_WAIT;
			end
		end
	end

	// data only moves while scl is low
	a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(scl && $past(scl) && $past(state) != ST_START_OUT && $past(state) != ST_STOP_OUT)
		|-> $stable(sda_line));

endmodule

/* src/i2c_transfer_ctrl.sv */
`timescale 1ns/100ps

module i2c_transfer_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cmd_req,
	input  i2c_pkg::i2c_cmd_t    cmd,
	output logic                 cmd_ack,
	output i2c_pkg::i2c_status_t status_out,
	output logic [7:0]           slave_addr,
	output logic [7:0]           remaining,
	output logic                 start,
	output logic                 stop,
	input  logic                 ack_done,
	input  i2c_pkg::i2c_status_t status,
	input  logic                 bus_idle,
	input  logic                 byte_pop,
	input  logic                 byte_push,
	output logic                 tx_pop,
	output logic                 scl_run
);

	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_FINISH, ST_ACK} state_t;

	state_t state;
	logic   drain;
	logic   count_en;

	// unsent write bytes are flushed after a nak
	assign drain    = (state == ST_FINISH) && !slave_addr[0] && (remaining != 8'd0);
	assign tx_pop   = (byte_pop && (remaining != 8'd0)) || drain;
	assign count_en = (byte_pop || byte_push || drain) && (remaining != 8'd0);
	assign scl_run  = (state == ST_RUN) || (state == ST_FINISH && !bus_idle);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			cmd_ack    <= 1'b0;
			status_out <= i2c_pkg::I2C_NO_ERR;
			remaining  <= '0;
			start      <= 1'b0;
			stop       <= 1'b0;
		end else begin
			start <= 1'b0;
			stop  <= 1'b0;
			if (count_en) remaining <= remaining - 8'd1;

			case (state)
				ST_IDLE: begin
					if (cmd_req) begin
						remaining  <= cmd.count;
						status_out <= i2c_pkg::I2C_NO_ERR;
						start      <= 1'b1;
						state      <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (ack_done) begin
						if (status != i2c_pkg::I2C_NO_ERR) begin
							status_out <= status; // first error wins
						end
						if (remaining == 8'd0 || status != i2c_pkg::I2C_NO_ERR) begin
							stop  <= 1'b1;
							state <= ST_FINISH;
						end
					end
				end
				ST_FINISH: begin
					if (bus_idle && !drain) begin
						cmd_ack <= 1'b1;
						state   <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						state   <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cmd_req) slave_addr <= cmd.slave_addr;
	end

	a_ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> cmd_req);

endmodule

/* src/i2c_master_top.sv */
`timescale 1ns/100ps

module i2c_master_top #(
	parameter int SCL_DIV    = 4,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cmd_req,
	input  i2c_pkg::i2c_cmd_t    cmd,
	output logic                 cmd_ack,
	output i2c_pkg::i2c_status_t status,
	input  logic                 tx_push,
	input  logic [7:0]           tx_data,
	output logic                 tx_full,
	input  logic                 rx_pop,
	output logic [7:0]           rx_data,
	output logic                 rx_empty,
	output logic                 scl,
	output logic                 sda_o,
	output logic                 sda_oe,
	input  logic                 sda_i
);

	logic [7:0]           slave_addr;
	logic [7:0]           remaining;
	logic                 start;
	logic                 stop;
	logic                 ack_done;
	i2c_pkg::i2c_status_t eng_status;
	logic                 bus_idle;
	logic                 byte_pop;
	logic                 byte_push;
	logic                 tx_pop;
	logic                 scl_run;
	logic                 scl_delay;
	logic [7:0]           tx_byte;
	logic [7:0]           rx_wdata;

	i2c_transfer_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
		.status_out(status), .slave_addr(slave_addr), .remaining(remaining),
		.start(start), .stop(stop), .ack_done(ack_done), .status(eng_status),
		.bus_idle(bus_idle), .byte_pop(byte_pop), .byte_push(byte_push),
		.tx_pop(tx_pop), .scl_run(scl_run)
	);

	i2c_bit_engine u_engine (
		.clk(clk), .rst_n(rst_n), .scl(scl), .scl_delay(scl_delay), .sda_i(sda_i),
		.sda_o(sda_o), .sda_oe(sda_oe), .slave_addr(slave_addr), .tx_byte(tx_byte),
		.byte_pop(byte_pop), .rx_byte(rx_wdata), .byte_push(byte_push),
		.remaining(remaining), .start(start), .stop(stop), .ack_done(ack_done),
		.status(eng_status), .bus_idle(bus_idle)
	);

	i2c_scl_gen #(.SCL_DIV(SCL_DIV)) u_scl_gen (
		.clk(clk), .rst_n(rst_n), .run(scl_run), .scl(scl), .scl_delay(scl_delay)
	);

	i2c_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
		.clk(clk), .rst_n(rst_n), .push(tx_push), .wr_data(tx_data), .pop(tx_pop),
		.rd_data(tx_byte), .full(tx_full), .empty()
	);

	i2c_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
		.clk(clk), .rst_n(rst_n), .push(byte_push), .wr_data(rx_wdata), .pop(rx_pop),
		.rd_data(rx_data), .full(), .empty(rx_empty)
	);

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* bench/i2c_slave_model.sv */
`timescale 1ns/100ps

module i2c_slave_model #(
	parameter logic [6:0] SLAVE_ADDR = 7'h50
) (
	input  logic       scl,
	input  logic       sda,
	input  logic [7:0] nak_after, // 0 means ack every byte
	output logic       sda_pull
);

	logic [7:0] mem [8];
	logic [7:0] shreg;
	logic [7:0] accepted;         // bytes stored or sent in this transfer
	logic       active;
	logic       addr_phase;
	logic       selected;
	logic       rd_mode;
	logic       stop_send;
	logic       scl_q;
	logic       sda_q;
	int         bit_cnt;

	initial begin
		for (int k = 0; k < 8; k++) mem[k] = 8'hA0 + 8'(k);
		sda_pull = 1'b0;
		active   = 1'b0;
		accepted = '0;
		selected = 1'b0;
		rd_mode  = 1'b0;
		scl_q    = 1'b1;
		sda_q    = 1'b1;
	end

	always @(scl or sda) begin
		if (scl !== scl_q) begin
			if (scl === 1'b1 && active) begin
				if (bit_cnt == 8) begin
					if (selected && rd_mode && sda === i2c_pkg::I2C_NAK) stop_send = 1'b1;
					bit_cnt = 0;
				end else begin
					if (!(selected && rd_mode)) shreg = {shreg[6:0], sda};
					bit_cnt = bit_cnt + 1;
				end
			end else if (scl === 1'b0 && active) begin
				if (bit_cnt == 8) begin
					if (addr_phase) begin
						addr_phase = 1'b0;
						selected   = (shreg[7:1] == SLAVE_ADDR);
						rd_mode    = shreg[0];
						sda_pull   = selected; // address ack
					end else if (selected && !rd_mode) begin
						if (nak_after == 8'd0 || accepted < nak_after) begin
							mem[accepted[2:0]] = shreg;
							accepted = accepted + 8'd1;
							sda_pull = 1'b1;
						end else begin
							sda_pull = 1'b0; // nak, byte dropped
						end
					end else begin
						sda_pull = 1'b0; // master answers on reads
					end
				end else begin
					if (bit_cnt == 0) begin
						sda_pull = 1'b0;
						if (selected && rd_mode && !stop_send) begin
							shreg    = mem[accepted[2:0]];
							accepted = accepted + 8'd1;
						end
					end
					if (selected && rd_mode && !stop_send) begin
						sda_pull = !shreg[7];
						shreg    = {shreg[6:0], 1'b0};
					end
				end
			end
		end else if (scl === 1'b1 && sda !== sda_q) begin
			if (sda === 1'b0) begin
				// start condition
				active     = 1'b1;
				addr_phase = 1'b1;
				selected   = 1'b0;
				stop_send  = 1'b0;
				accepted   = '0;
				bit_cnt    = 0;
				sda_pull   = 1'b0;
			end else if (sda === 1'b1) begin
				active   = 1'b0; // stop
				sda_pull = 1'b0;
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

/* bench/tb_i2c_master.sv */
`timescale 1ns/100ps

module tb_i2c_master;

	localparam int SCL_DIV    = 4;
	localparam int FIFO_DEPTH = 16;
	localparam int NUM_ROWS   = 4;

	typedef struct {
		string                name;
		logic [7:0]           addr;
		int                   count;
		int                   nak_after;
		i2c_pkg::i2c_status_t exp_status;
		int                   exp_bytes;
	} row_t;

	logic                 clk;
	logic                 rst_n;
	logic                 cmd_req;
	i2c_pkg::i2c_cmd_t    cmd;
	logic                 cmd_ack;
	i2c_pkg::i2c_status_t status;
	logic                 tx_push;
	logic [7:0]           tx_data;
	logic                 tx_full;
	logic                 rx_pop;
	logic [7:0]           rx_data;
	logic                 rx_empty;
	logic                 scl;
	logic                 sda_o;
	logic                 sda_oe;
	logic                 slave_pull;
	logic [7:0]           nak_after;
	wire                  sda_bus;

	row_t       rows [NUM_ROWS];
	logic [7:0] exp_mem [8];
	logic [7:0] wdata [FIFO_DEPTH];
	integer     seed;
	int         cycles;
	int         limit;
	int         test_errors;
	int         pass_cnt;
	int         fail_cnt;

	// either side can pull the open-drain bus low
	assign sda_bus = ((sda_oe && !sda_o) || slave_pull) ? 1'b0 : 1'b1;

	tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

	i2c_slave_model #(.SLAVE_ADDR(7'h50)) u_slave (
		.scl(scl), .sda(sda_bus), .nak_after(nak_after), .sda_pull(slave_pull)
	);

	i2c_master_top #(.SCL_DIV(SCL_DIV), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
		.clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
		.status(status), .tx_push(tx_push), .tx_data(tx_data), .tx_full(tx_full),
		.rx_pop(rx_pop), .rx_data(rx_data), .rx_empty(rx_empty), .scl(scl),
		.sda_o(sda_o), .sda_oe(sda_oe), .sda_i(sda_bus)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string sig, input int exp_val, input int act_val);
		$display("Mismatch %s: expected %h, got %h", sig, exp_val, act_val);
		test_errors++;
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0) begin
			$display("PASS %s", name);
			pass_cnt++;
		end else begin
			$display("FAIL %s (%0d errors)", name, test_errors);
			fail_cnt++;
		end
	endtask

	task automatic wait_ack_level(input logic level);
		do @(negedge clk); while (cmd_ack !== level);
	endtask

	task automatic run_row(input int i);
		row_t r;
		r = rows[i];
		test_errors = 0;
		@(posedge clk);
		nak_after <= 8'(r.nak_after);
		if (!r.addr[0]) begin
			for (int b = 0; b < r.count; b++) begin
				wdata[b] = 8'($random(seed));
				@(posedge clk);
				tx_push <= 1'b1;
				tx_data <= wdata[b];
			end
			@(posedge clk);
			tx_push <= 1'b0;
			@(negedge clk);
			if (tx_full !== (r.count >= FIFO_DEPTH)) begin
				report_mismatch("tx_full", int'(r.count >= FIFO_DEPTH), int'(tx_full));
			end
		end
		@(posedge clk);
		cmd     <= {r.addr, 8'(r.count)};
		cmd_req <= 1'b1;
		wait_ack_level(1'b1);
		if (status !== r.exp_status) begin
			report_mismatch("status", int'(r.exp_status), int'(status));
		end
		repeat (2) begin // host keeps req up a little longer
			@(negedge clk);
			if (cmd_ack !== 1'b1) begin
				$display("cmd_ack fell while cmd_req was still high");
				test_errors++;
			end
		end
		@(posedge clk);
		cmd_req <= 1'b0;
		wait_ack_level(1'b0);
		if (int'(u_slave.accepted) != r.exp_bytes) begin
			report_mismatch("accepted", r.exp_bytes, int'(u_slave.accepted));
		end
		if (!r.addr[0]) begin
			for (int k = 0; k < r.exp_bytes; k++) exp_mem[k] = wdata[k];
		end
		for (int k = 0; k < 8; k++) begin
			if (u_slave.mem[k] !== exp_mem[k]) begin
				report_mismatch($sformatf("slave mem[%0d]", k), int'(exp_mem[k]),
					int'(u_slave.mem[k]));
			end
		end
		if (r.addr[0]) begin
			for (int b = 0; b < r.count; b++) begin
				if (rx_empty !== 1'b0) begin
					$display("receive FIFO ran empty before byte %0d", b);
					test_errors++;
				end
				@(posedge clk);
				rx_pop <= 1'b1;
				@(posedge clk);
				rx_pop <= 1'b0;
				@(negedge clk);
				if (rx_data !== exp_mem[b]) begin
					report_mismatch("rx_data", int'(exp_mem[b]), int'(rx_data));
				end
			end
			if (rx_empty !== 1'b1) report_mismatch("rx_empty", 1, int'(rx_empty));
		end
		close_test(r.name);
	endtask

	initial begin
		seed     = 33632;
		cycles   = 0;
		limit    = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		cmd_req   = 1'b0;
		cmd       = '0;
		tx_push   = 1'b0;
		tx_data   = '0;
		rx_pop    = 1'b0;
		nak_after = '0;
		for (int k = 0; k < 8; k++) exp_mem[k] = 8'hA0 + 8'(k);

		// read first while the preload is intact
		rows[0] = '{"read_5", {7'h50, 1'b1}, 5, 0, i2c_pkg::I2C_NO_ERR, 5};
		rows[1] = '{"write_4", {7'h50, 1'b0}, 4, 0, i2c_pkg::I2C_NO_ERR, 4};
		rows[2] = '{"absent_addr", {7'h3A, 1'b0}, 4, 0, i2c_pkg::I2C_ERR_NO_ADDR_ACK, 0};
		rows[3] = '{"data_nak", {7'h50, 1'b0}, 4, 2, i2c_pkg::I2C_ERR_NO_DATA_ACK, 2};
		for (int i = 0; i < NUM_ROWS; i++) begin
			limit += (rows[i].count + 2) * 9 * 2 * SCL_DIV + 200;
		end

		@(posedge clk);
		while (rst_n !== 1'b1) @(posedge clk);
		@(negedge clk);
		test_errors = 0;
		if (scl !== 1'b1) report_mismatch("scl", 1, int'(scl));
		if (sda_o !== 1'b1) report_mismatch("sda_o", 1, int'(sda_o));
		if (sda_oe !== 1'b0) report_mismatch("sda_oe", 0, int'(sda_oe));
		if (cmd_ack !== 1'b0) report_mismatch("cmd_ack", 0, int'(cmd_ack));
		if (tx_full !== 1'b0) report_mismatch("tx_full", 0, int'(tx_full));
		if (rx_empty !== 1'b1) report_mismatch("rx_empty", 1, int'(rx_empty));
		close_test("reset_state");

		for (int i = 0; i < NUM_ROWS; i++) run_row(i);

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
src/i2c_pkg.sv
src/i2c_scl_gen.sv
src/i2c_byte_fifo.sv
src/i2c_bit_engine.sv
src/i2c_transfer_ctrl.sv
src/i2c_master_top.sv
bench/tb_clock_gen.sv
bench/i2c_slave_model.sv
bench/tb_i2c_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
LOG       ?= sim.log
OBJ       ?= obj_dir
FLAGS     ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f vlog.f --top-module $(TOP) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) $(LOG)
